// ==== compile.f ====
+incdir+.
hsi_types_pkg.sv
hsi_ctrl_pkg.sv
hsi_ifs.sv
hsi_axil_regs.sv
spectral_store.sv
match_sequencer.sv
sq_df_acc.sv
mse.sv
hsi_match_top.sv
hsi_match_assert.sv
tb_hsi_match.sv

// ==== hsi_axil_regs.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module hsi_axil_regs import hsi_types_pkg::*, hsi_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`HSI_AXI_AW-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  word_t                  wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output axi_resp_e              bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`HSI_AXI_AW-1:0] araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output word_t                  rdata,
  output axi_resp_e              rresp,
  output logic                   rvalid,
  input  logic                   rready,
  input  word_t                  mse_value,
  input  lib_ref_t               mse_ref,
  input  logic                   mse_valid,
  input  logic                   issue_done,
  output logic                   go,
  output logic                   irq,
  buf_wr_if.writer               buf_wr
);

  logic                   wr_hs, rd_hs, ctrl_wr, start_run;
  logic                   pix_hit, lib_hit, last_res;
  logic [`HSI_AXI_AW-1:0] pix_off, lib_off;
  logic                   busy, done, issuing, first_res;
  lib_ref_t               best_ref;
  word_t                  best_mse;

  assign wr_hs   = awvalid && wvalid && !bvalid;  // One write response outstanding at most
  assign rd_hs   = arvalid && !rvalid;
  assign awready = wr_hs;
  assign wready  = wr_hs;
  assign arready = rd_hs;

  assign pix_off = awaddr - `HSI_PIX_BASE;  // Wraps high below the base
  assign lib_off = awaddr - `HSI_LIB_BASE;
  assign pix_hit = (pix_off < 4 * `HSI_BANDS) && (awaddr[1:0] == 2'b00);
  assign lib_hit = (lib_off < 4 * `HSI_BANDS * `HSI_LIBRARY_SIZE) && (awaddr[1:0] == 2'b00);

  assign ctrl_wr   = wr_hs && (awaddr == `HSI_ADDR_CTRL);
  assign start_run = ctrl_wr && wdata[0] && !busy;  // Ignored while a run is busy
  assign last_res  = mse_valid && busy && !issuing
                     && (mse_ref == lib_ref_t'(`HSI_LIBRARY_SIZE - 1));

  // Write channel and buffer write strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid    <= 1'b0;
      bresp     <= OKAY;
      buf_wr.we <= 1'b0;
      go        <= 1'b0;
    end else begin
      buf_wr.we <= 1'b0;
      go        <= start_run;  // Single cycle pulse
      if (bvalid && bready)
        bvalid <= 1'b0;
      if (wr_hs) begin
        bvalid <= 1'b1;
        if (ctrl_wr) begin
          bresp <= OKAY;
        end else if ((pix_hit || lib_hit) && !busy) begin
          bresp     <= OKAY;
          buf_wr.we <= 1'b1;
        end else begin
          bresp <= SLVERR;  // Unmapped, read only, or window write during a run
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      buf_wr.lib_sel <= lib_hit;
      buf_wr.addr    <= lib_hit ? lib_off[2 +: `HSI_LIB_AW]
                                : {{`HSI_REF_AW{1'b0}}, pix_off[2 +: `HSI_BAND_AW]};
      buf_wr.data    <= wdata;
    end
  end

  // Run control and best match tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      irq       <= 1'b0;
      issuing   <= 1'b0;
      first_res <= 1'b0;
      best_ref  <= '0;
      best_mse  <= '0;
    end else begin
      if (ctrl_wr)
        irq <= 1'b0;  // Any CTRL write acknowledges the interrupt
      if (start_run) begin
        busy      <= 1'b1;
        done      <= 1'b0;
        issuing   <= 1'b1;
        first_res <= 1'b1;
      end
      if (issue_done)
        issuing <= 1'b0;  // Sequencer has sent its final element
      if (mse_valid && busy) begin
        first_res <= 1'b0;
        if (first_res || (mse_value < best_mse)) begin  // Ties keep the lower entry
          best_mse <= mse_value;
          best_ref <= mse_ref;
        end
      end
      if (last_res) begin
        busy <= 1'b0;
        done <= 1'b1;
        irq  <= 1'b1;
      end
    end
  end

  // Read channel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (rd_hs)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      rresp <= OKAY;
      rdata <= '0;
      case (araddr)
        `HSI_ADDR_CTRL:     rdata <= '0;  // Start bit reads back clear
        `HSI_ADDR_STATUS:   rdata <= word_t'({done, busy});
        `HSI_ADDR_BEST_REF: rdata <= word_t'(best_ref);
        `HSI_ADDR_BEST_MSE: rdata <= best_mse;
        default:            rresp <= SLVERR;  // Windows are write only
      endcase
    end
  end

endmodule

// ==== hsi_ctrl_pkg.sv ====
package hsi_ctrl_pkg;

  // AXI4-Lite response codes in use
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Library walk
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN  // Last read issued, last element still in flight
  } seq_state_e;

endpackage

// ==== hsi_defines.svh ====
`ifndef HSI_DEFINES_SVH
`define HSI_DEFINES_SVH

`define HSI_WORD_WIDTH   32  // Two samples per bus word
`define HSI_DATA_WIDTH   16  // Signed band sample
`define HSI_ACC_WIDTH    48  // Headroom for a full vector of squares
`define HSI_BANDS        8   // Words per spectrum
`define HSI_LIBRARY_SIZE 4   // Reference spectra in the library
`define HSI_BAND_AW      $clog2(`HSI_BANDS)
`define HSI_REF_AW       $clog2(`HSI_LIBRARY_SIZE)
`define HSI_LIB_AW       (`HSI_BAND_AW + `HSI_REF_AW)  // Flat library word index
`define HSI_AXI_AW       12  // Byte address into the register space

`define HSI_ADDR_CTRL     12'h000  // Bit 0 starts a run
`define HSI_ADDR_STATUS   12'h004  // Busy in bit 0, done in bit 1
`define HSI_ADDR_BEST_REF 12'h008
`define HSI_ADDR_BEST_MSE 12'h00C
`define HSI_PIX_BASE      12'h100  // One word per band
`define HSI_LIB_BASE      12'h200  // Entry major, band minor

`endif

// ==== hsi_ifs.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

// Register block to spectral store, written in the cycle we is high
interface buf_wr_if import hsi_types_pkg::*; ();
  logic                   we;
  logic                   lib_sel;  // Library memory when set, pixel memory otherwise
  logic [`HSI_LIB_AW-1:0] addr;     // Pixel writes use only the band bits
  word_t                  data;

  modport writer (output we, lib_sel, addr, data);
  modport store  (input we, lib_sel, addr, data);
endinterface

// Sequencer to spectral store, data one cycle after re
interface buf_rd_if import hsi_types_pkg::*; ();
  logic                   re;
  band_t                  pix_addr;
  logic [`HSI_LIB_AW-1:0] lib_addr;  // {entry, band}
  word_t                  pix_data;
  word_t                  lib_data;

  modport reader (output re, pix_addr, lib_addr, input pix_data, lib_data);
  modport store  (input re, pix_addr, lib_addr, output pix_data, lib_data);
endinterface

// Pixel and library element pairs, consumer never stalls
interface elem_stream_if import hsi_types_pkg::*; ();
  logic     valid;
  logic     start;      // First band of an entry
  logic     last;       // Final band of an entry
  lib_ref_t vctr_ref;   // Entry index
  word_t    element_a;  // Pixel word
  word_t    element_b;  // Library word

  modport producer (output valid, start, last, vctr_ref, element_a, element_b);
  modport consumer (input valid, start, last, vctr_ref, element_a, element_b);
endinterface

// ==== hsi_match_assert.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module hsi_match_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       bvalid,
  input logic                       bready,
  input logic                       rvalid,
  input logic                       rready,
  input logic [`HSI_WORD_WIDTH-1:0] rdata,
  input logic                       irq
);

  int unsigned violations = 0;  // Failed assertions so far, watched by the testbench

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)  // Write response waits for bready
    else begin
      $error("bvalid dropped before bready");
      violations++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))  // Read data frozen while stalled
    else begin
      $error("rvalid or rdata changed before rready");
      violations++;
    end

  irq_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !irq && !bvalid && !rvalid)  // Quiet outputs as reset releases
    else begin
      $error("irq or a response valid high at reset release");
      violations++;
    end

endmodule

bind hsi_match_top hsi_match_assert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .irq     (irq)
);

// ==== hsi_match_top.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module hsi_match_top import hsi_types_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`HSI_AXI_AW-1:0]    awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`HSI_WORD_WIDTH-1:0] wdata,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`HSI_AXI_AW-1:0]    araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic [`HSI_WORD_WIDTH-1:0] rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  output logic                      irq  // Run finished, cleared by a CTRL write
);

  buf_wr_if      buf_wr ();
  buf_rd_if      buf_rd ();
  elem_stream_if strm ();

  logic     go, issue_done, mse_valid;
  word_t    mse_value;
  lib_ref_t mse_ref;

  hsi_axil_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .mse_value  (mse_value),
    .mse_ref    (mse_ref),
    .mse_valid  (mse_valid),
    .issue_done (issue_done),
    .go         (go),
    .irq        (irq),
    .buf_wr     (buf_wr.writer)
  );

  spectral_store u_store (
    .clk    (clk),
    .rst_n  (rst_n),
    .buf_wr (buf_wr.store),
    .buf_rd (buf_rd.store)
  );

  match_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (go),
    .issue_done (issue_done),
    .buf_rd     (buf_rd.reader),
    .strm       (strm.producer)
  );

  mse u_mse (
    .clk       (clk),
    .rst_n     (rst_n),
    .strm      (strm.consumer),
    .mse_value (mse_value),
    .mse_ref   (mse_ref),
    .mse_valid (mse_valid)
  );

endmodule

// ==== hsi_types_pkg.sv ====
`include "hsi_defines.svh"

package hsi_types_pkg;

  // Sample and word formats
  typedef logic signed [`HSI_DATA_WIDTH-1:0] sample_t;  // One band sample
  typedef logic [`HSI_WORD_WIDTH-1:0] word_t;            // Low and high sample pair

  // Arithmetic widths
  typedef logic [2*`HSI_DATA_WIDTH-1:0] sq_t;  // Square of a 17 bit difference, never negative
  typedef logic [`HSI_ACC_WIDTH-1:0] acc_t;    // Running sum over one vector

  // Indices
  typedef logic [`HSI_REF_AW-1:0] lib_ref_t;  // Library entry
  typedef logic [`HSI_BAND_AW-1:0] band_t;    // Word inside a vector

endpackage

// ==== match_sequencer.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module match_sequencer import hsi_types_pkg::*, hsi_ctrl_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            go,
  output logic            issue_done,
  buf_rd_if.reader        buf_rd,
  elem_stream_if.producer strm
);

  seq_state_e state;
  band_t      band;
  lib_ref_t   ref_idx;
  logic       last_band, last_ref;

  assign last_band = (band == band_t'(`HSI_BANDS - 1));
  assign last_ref  = (ref_idx == lib_ref_t'(`HSI_LIBRARY_SIZE - 1));

  assign buf_rd.re       = (state == RUN);  // One read per cycle, no gaps
  assign buf_rd.pix_addr = band;
  assign buf_rd.lib_addr = {ref_idx, band};
  assign strm.element_a  = buf_rd.pix_data;
  assign strm.element_b  = buf_rd.lib_data;
  assign issue_done      = (state == DRAIN);  // Final element is on the stream

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      band    <= '0;
      ref_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          band    <= '0;
          ref_idx <= '0;
          if (go)
            state <= RUN;
        end
        RUN: begin
          band <= band + 1'b1;  // Wraps to band 0 on the next entry
          if (last_band)
            ref_idx <= ref_idx + 1'b1;
          if (last_band && last_ref)
            state <= DRAIN;
        end
        default: state <= IDLE;  // DRAIN lasts one cycle
      endcase
    end
  end

  // Side band delayed by one cycle to meet the read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strm.valid    <= 1'b0;
      strm.start    <= 1'b0;
      strm.last     <= 1'b0;
      strm.vctr_ref <= '0;
    end else begin
      strm.valid    <= buf_rd.re;
      strm.start    <= buf_rd.re && (band == '0);
      strm.last     <= buf_rd.re && last_band;
      strm.vctr_ref <= ref_idx;
    end
  end

endmodule

// ==== mse.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module mse import hsi_types_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  elem_stream_if.consumer strm,
  output word_t           mse_value,
  output lib_ref_t        mse_ref,
  output logic            mse_valid
);

  logic     lo_valid, hi_valid, lo_last, hi_last;
  acc_t     lo_value, hi_value;
  lib_ref_t lo_ref, hi_ref;
  logic     init_en, acc_sum_en;
  logic     sum_valid;
  acc_t     sum_value;  // Both channels fit with room to spare
  lib_ref_t sum_ref;

  assign init_en    = strm.valid && strm.start;
  assign acc_sum_en = lo_valid && hi_valid && lo_last && hi_last
                      && (lo_ref == hi_ref);  // Both channels closed the same entry

  sq_df_acc u_ch_lo (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (strm.valid),
    .initial_acc_en (init_en),
    .data_in_a      (strm.element_a[`HSI_DATA_WIDTH-1:0]),  // Lower sample
    .data_in_b      (strm.element_b[`HSI_DATA_WIDTH-1:0]),
    .data_in_ref    (strm.vctr_ref),
    .data_in_last   (strm.last),
    .acc_valid      (lo_valid),
    .acc_value      (lo_value),
    .acc_last       (lo_last),
    .acc_ref        (lo_ref)
  );

  sq_df_acc u_ch_hi (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (strm.valid),
    .initial_acc_en (init_en),
    .data_in_a      (strm.element_a[`HSI_WORD_WIDTH-1:`HSI_DATA_WIDTH]),  // Upper sample
    .data_in_b      (strm.element_b[`HSI_WORD_WIDTH-1:`HSI_DATA_WIDTH]),
    .data_in_ref    (strm.vctr_ref),
    .data_in_last   (strm.last),
    .acc_valid      (hi_valid),
    .acc_value      (hi_value),
    .acc_last       (hi_last),
    .acc_ref        (hi_ref)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      sum_value <= '0;
      sum_ref   <= '0;
      mse_valid <= 1'b0;
      mse_value <= '0;
      mse_ref   <= '0;
    end else begin
      sum_valid <= acc_sum_en;  // Channel sum stage
      if (acc_sum_en) begin
        sum_value <= lo_value + hi_value;
        sum_ref   <= lo_ref;
      end
      mse_valid <= sum_valid;  // Mean stage
      if (sum_valid) begin
        mse_value <= word_t'(sum_value >> `HSI_BAND_AW);  // Divide by the band count
        mse_ref   <= sum_ref;
      end
    end
  end

endmodule

// ==== spectral_store.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module spectral_store import hsi_types_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  buf_wr_if.store  buf_wr,
  buf_rd_if.store  buf_rd
);

  word_t pix_mem [`HSI_BANDS];                      // Pixel spectrum
  word_t lib_mem [`HSI_BANDS * `HSI_LIBRARY_SIZE];  // Reference spectra, entry major

  // Single write port shared by both memories
  always_ff @(posedge clk) begin
    if (buf_wr.we) begin
      if (buf_wr.lib_sel)
        lib_mem[buf_wr.addr] <= buf_wr.data;
      else
        pix_mem[band_t'(buf_wr.addr)] <= buf_wr.data;  // Band bits only
    end
  end

  // Common read strobe, data registered one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_rd.pix_data <= '0;
      buf_rd.lib_data <= '0;
    end else if (buf_rd.re) begin
      buf_rd.pix_data <= pix_mem[buf_rd.pix_addr];
      buf_rd.lib_data <= lib_mem[buf_rd.lib_addr];
    end
  end

endmodule

// ==== sq_df_acc.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module sq_df_acc import hsi_types_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     data_in_valid,
  input  logic     initial_acc_en,  // Restart the sum with this element
  input  sample_t  data_in_a,
  input  sample_t  data_in_b,
  input  lib_ref_t data_in_ref,
  input  logic     data_in_last,
  output logic     acc_valid,
  output acc_t     acc_value,
  output logic     acc_last,
  output lib_ref_t acc_ref
);

  logic                              s1_valid, s1_init, s1_last;
  lib_ref_t                          s1_ref;
  logic signed [`HSI_DATA_WIDTH:0]   s1_diff;  // One extra bit, no wrap on extremes
  logic                              s2_valid, s2_init, s2_last;
  lib_ref_t                          s2_ref;
  sq_t                               s2_sq;
  logic signed [2*`HSI_DATA_WIDTH+1:0] sq_full;

  assign sq_full = s1_diff * s1_diff;  // Upper bits always zero

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_init   <= 1'b0;
      s1_last   <= 1'b0;
      s1_ref    <= '0;
      s1_diff   <= '0;
      s2_valid  <= 1'b0;
      s2_init   <= 1'b0;
      s2_last   <= 1'b0;
      s2_ref    <= '0;
      s2_sq     <= '0;
      acc_valid <= 1'b0;
      acc_last  <= 1'b0;
      acc_ref   <= '0;
      acc_value <= '0;
    end else begin
      // Stage 1, difference
      s1_valid <= data_in_valid;
      s1_init  <= data_in_valid && initial_acc_en;
      s1_last  <= data_in_valid && data_in_last;
      s1_ref   <= data_in_ref;
      s1_diff  <= data_in_a - data_in_b;
      // Stage 2, square
      s2_valid <= s1_valid;
      s2_init  <= s1_init;
      s2_last  <= s1_last;
      s2_ref   <= s1_ref;
      s2_sq    <= sq_full[2*`HSI_DATA_WIDTH-1:0];
      // Stage 3, accumulate
      acc_valid <= s2_valid;
      acc_last  <= s2_last;
      acc_ref   <= s2_ref;
      if (s2_valid)
        acc_value <= s2_init ? acc_t'(s2_sq) : acc_value + acc_t'(s2_sq);
    end
  end

endmodule

// ==== tb_hsi_match.sv ====
`timescale 1ns/1ns
`include "hsi_defines.svh"

module tb_hsi_match;

  localparam int BANDS      = `HSI_BANDS;
  localparam int ENTRIES    = `HSI_LIBRARY_SIZE;
  localparam int BAND_SHIFT = $clog2(`HSI_BANDS);  // Mean over the band count
  localparam int MAX_CYCLES = 2000;  // Four runs of ~40 cycles, ~130 accesses of ~5 cycles
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                       clk, rst_n;
  logic [`HSI_AXI_AW-1:0]     awaddr, araddr;
  logic [`HSI_WORD_WIDTH-1:0] wdata, rdata;
  logic                       awvalid, wvalid, bready, arvalid, rready;
  logic                       awready, wready, bvalid, arready, rvalid, irq;
  logic [1:0]                 bresp, rresp;

  logic [31:0] pix [BANDS];          // Model copy of the pixel spectrum
  logic [31:0] lib [BANDS*ENTRIES];  // Model copy of the library, entry major
  int unsigned cycles = 0;

  hsi_match_top u_hsi_match_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      abort_run();
    end
  end

  always @(negedge clk) begin
    if (u_hsi_match_top.u_assert.violations != 0) begin
      $display("A protocol assertion on the AXI ports failed");
      abort_run();
    end
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
        abort_run();
      end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;  // Drive point after the edge
  endtask

  // AXI write with a random bready stall, checks the response code
  task automatic store_word(input logic [11:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int unsigned stall;
    stall   = $urandom_range(0, 3);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_equal("wready", 32'h1, 32'(wready));  // Data taken with the address
    step_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    repeat (stall) step_cycle();  // bvalid must hold meanwhile
    bready = 1'b1;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    check_equal("bresp", exp_resp, bresp);
    step_cycle();
    bready = 1'b0;
  endtask

  // AXI read with a random rready stall
  task automatic fetch_word(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
    int unsigned stall;
    stall   = $urandom_range(0, 3);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    step_cycle();
    arvalid = 1'b0;
    repeat (stall) step_cycle();  // rvalid and rdata must hold meanwhile
    rready = 1'b1;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    step_cycle();
    rready = 1'b0;
  endtask

  task automatic verify_read(input string name, input logic [11:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    fetch_word(addr, data, resp);
    check_equal({name, " rresp"}, RESP_OKAY, resp);
    check_equal(name, exp, data);
  endtask

  task automatic wait_for_irq();
    @(negedge clk);
    while (!irq) @(negedge clk);  // Global cycle counter bounds this wait
    step_cycle();
  endtask

  task automatic run_to_irq();
    store_word(`HSI_ADDR_CTRL, 32'h1, RESP_OKAY);
    wait_for_irq();
  endtask

  task automatic load_memories();
    int i;
    for (i = 0; i < BANDS; i++)
      store_word(12'(`HSI_PIX_BASE + 4 * i), pix[i], RESP_OKAY);
    for (i = 0; i < BANDS * ENTRIES; i++)
      store_word(12'(`HSI_LIB_BASE + 4 * i), lib[i], RESP_OKAY);
  endtask

  // Sum of squared differences over both halves, then divided by the band count
  function automatic longint model_error(input int entry);
    longint sum, d_lo, d_hi;
    logic [31:0] a, b;
    int band;
    sum = 0;
    for (band = 0; band < BANDS; band++) begin
      a    = pix[band];
      b    = lib[entry * BANDS + band];
      d_lo = longint'($signed(a[15:0])) - longint'($signed(b[15:0]));
      d_hi = longint'($signed(a[31:16])) - longint'($signed(b[31:16]));
      sum  = sum + d_lo * d_lo + d_hi * d_hi;
    end
    return sum >> BAND_SHIFT;
  endfunction

  function automatic void model_best(output int best_ref, output longint best_err);
    longint err;
    int e;
    best_ref = 0;
    best_err = model_error(0);
    for (e = 1; e < ENTRIES; e++) begin
      err = model_error(e);
      if (err < best_err) begin  // Strictly smaller, ties stay with the lower entry
        best_ref = e;
        best_err = err;
      end
    end
  endfunction

  task automatic check_best();
    int     exp_ref;
    longint exp_err;
    model_best(exp_ref, exp_err);
    verify_read("BEST_REF", `HSI_ADDR_BEST_REF, 32'(exp_ref));
    verify_read("BEST_MSE", `HSI_ADDR_BEST_MSE, exp_err[31:0]);
  endtask

  function automatic logic [15:0] small_sample();
    return 16'($urandom_range(0, 8191)) - 16'd4096;  // Signed 13 bit range
  endfunction

  function automatic logic [31:0] offset_word(input logic [31:0] w, input int off);
    return {w[31:16] + 16'(off), w[15:0] + 16'(off)};
  endfunction

  function automatic void fill_random();
    int i;
    for (i = 0; i < BANDS; i++)
      pix[i] = {small_sample(), small_sample()};
    for (i = 0; i < BANDS * ENTRIES; i++)
      lib[i] = {small_sample(), small_sample()};
  endfunction

  // Entries 1 and 3 share the smallest error
  function automatic void fill_tie();
    int e, b;
    for (b = 0; b < BANDS; b++)
      pix[b] = {small_sample(), small_sample()};
    for (e = 0; e < ENTRIES; e++)
      for (b = 0; b < BANDS; b++)
        lib[e * BANDS + b] = offset_word(pix[b], (e % 2 == 1) ? 100 : 500);
  endfunction

  // Most negative against most positive, fewer extreme bands on higher entries
  function automatic void fill_extreme();
    int e, b;
    for (b = 0; b < BANDS; b++)
      pix[b] = {16'h8000, 16'h7FFF};
    for (e = 0; e < ENTRIES; e++)
      for (b = 0; b < BANDS; b++)
        lib[e * BANDS + b] = (b < ENTRIES - e) ? {16'h7FFF, 16'h8000} : pix[b];
  endfunction

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    void'($urandom(13));  // Seeds the generator of this thread
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    step_cycle();

    verify_read("STATUS", `HSI_ADDR_STATUS, 32'h0);  // Reset values
    verify_read("BEST_REF", `HSI_ADDR_BEST_REF, 32'h0);
    verify_read("BEST_MSE", `HSI_ADDR_BEST_MSE, 32'h0);
    fetch_word(12'h010, data, resp);  // Unmapped read
    check_equal("rresp", RESP_SLVERR, resp);
    store_word(12'h800, 32'hDEAD_BEEF, RESP_SLVERR);  // Unmapped write

    fill_random();
    load_memories();
    store_word(`HSI_ADDR_CTRL, 32'h1, RESP_OKAY);
    verify_read("STATUS", `HSI_ADDR_STATUS, 32'h1);  // Busy
    store_word(`HSI_PIX_BASE, 32'h1234_5678, RESP_SLVERR);  // Window locked during a run
    store_word(`HSI_ADDR_CTRL, 32'h1, RESP_OKAY);  // Start while busy is ignored
    wait_for_irq();
    verify_read("STATUS", `HSI_ADDR_STATUS, 32'h2);  // Done
    check_best();
    store_word(`HSI_ADDR_CTRL, 32'h0, RESP_OKAY);
    check_equal("irq", 32'h0, 32'(irq));  // Cleared by the CTRL write
    run_to_irq();  // Same data again
    check_best();

    fill_tie();
    load_memories();
    run_to_irq();
    check_best();

    fill_extreme();
    load_memories();
    run_to_irq();
    check_best();

    if (u_hsi_match_top.u_assert.violations == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("A protocol assertion on the AXI ports failed");
      abort_run();
    end
  end

endmodule
